//--- sources.f
+incdir+source
+incdir+tests
source/core_pkg.sv
source/stage_ctrl.sv
source/id_stage.sv
source/reg_file.sv
source/exec_unit.sv
source/lsu.sv
source/mem_array.sv
source/rv_core_top.sv
tests/core_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module core_tb -f sources.f -o core_sim \
  && ./obj_dir/core_sim | tee /dev/stderr | grep -qF -- '** PASS **' \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- tests/tb_programs.svh
// test program for the core: instruction words and hand-derived retire records
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
localparam logic [6:0] OPC_OP     = 7'b0110011;
localparam logic [6:0] OPC_LUI    = 7'b0110111;
localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
localparam logic [6:0] OPC_LOAD   = 7'b0000011;
localparam logic [6:0] OPC_JALR   = 7'b1100111;

logic [31:0] prog    [64];
logic [63:0] exp_pc  [64];
logic [4:0]  exp_rd  [64];
logic        exp_wen [64];
logic [63:0] exp_val [64];
int          prog_n;
int          rec_n;

function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd,
                                       input logic [6:0] opc);
  return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [4:0] rd);
  return {f7, rs2, rs1, 3'b000, rd, OPC_OP};
endfunction

function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
  return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                       input logic [6:0] opc);
  return {imm, rd, opc};
endfunction

function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
endfunction

task automatic put_word(input logic [31:0] word);
  prog[prog_n] = word;
  prog_n++;
endtask

task automatic expect_retire(input logic [63:0] pc, input logic [4:0] rd, input logic wen,
                             input logic [63:0] val);
  exp_pc[rec_n]  = pc;
  exp_rd[rec_n]  = rd;
  exp_wen[rec_n] = wen;
  exp_val[rec_n] = val;
  rec_n++;
endtask

task automatic build_program();
  prog_n = 0;
  rec_n  = 0;
  // arithmetic, x0 and upper immediates
  put_word(i_type(12'd5, 0, 3'b000, 1, OPC_OP_IMM));
  expect_retire(0, 1, 1, 64'd5);
  put_word(i_type(12'hffd, 0, 3'b000, 2, OPC_OP_IMM));
  expect_retire(4, 2, 1, 64'hffff_ffff_ffff_fffd);
  put_word(r_type(7'h00, 2, 1, 3));
  expect_retire(8, 3, 1, 64'd2);
  put_word(r_type(7'h20, 1, 2, 4));
  expect_retire(12, 4, 1, 64'hffff_ffff_ffff_fff8);
  put_word(i_type(12'd7, 1, 3'b000, 0, OPC_OP_IMM));
  expect_retire(16, 0, 0, 64'd0);
  put_word(r_type(7'h00, 1, 0, 5));
  expect_retire(20, 5, 1, 64'd5);
  put_word(u_type(20'h12345, 6, OPC_LUI));
  expect_retire(24, 6, 1, 64'h0000_0000_1234_5000);
  put_word(u_type(20'h80000, 7, OPC_LUI));
  expect_retire(28, 7, 1, 64'hffff_ffff_8000_0000);
  put_word(u_type(20'h00001, 8, OPC_AUIPC));
  expect_retire(32, 8, 1, 64'h1020);
  put_word(i_type(12'h100, 0, 3'b000, 9, OPC_OP_IMM));
  expect_retire(36, 9, 1, 64'h100);
  put_word(u_type(20'h87654, 10, OPC_LUI));
  expect_retire(40, 10, 1, 64'hffff_ffff_8765_4000);
  put_word(i_type(12'h321, 10, 3'b000, 10, OPC_OP_IMM));
  expect_retire(44, 10, 1, 64'hffff_ffff_8765_4321);
  // stores of every width into one word, then loads back
  put_word(s_type(12'd0, 10, 9, 3'b011));
  expect_retire(48, 0, 0, 64'd0);
  put_word(s_type(12'd4, 1, 9, 3'b010));
  expect_retire(52, 0, 0, 64'd0);
  put_word(s_type(12'd2, 2, 9, 3'b001));
  expect_retire(56, 0, 0, 64'd0);
  put_word(s_type(12'd1, 3, 9, 3'b000));
  expect_retire(60, 0, 0, 64'd0);
  put_word(i_type(12'd0, 9, 3'b011, 11, OPC_LOAD));
  expect_retire(64, 11, 1, 64'h0000_0005_fffd_0221);
  put_word(i_type(12'd0, 9, 3'b010, 12, OPC_LOAD));
  expect_retire(68, 12, 1, 64'hffff_ffff_fffd_0221);
  put_word(i_type(12'd2, 9, 3'b001, 13, OPC_LOAD));
  expect_retire(72, 13, 1, 64'hffff_ffff_ffff_fffd);
  put_word(i_type(12'd1, 9, 3'b000, 14, OPC_LOAD));
  expect_retire(76, 14, 1, 64'd2);
  put_word(i_type(12'd4, 9, 3'b010, 15, OPC_LOAD));
  expect_retire(80, 15, 1, 64'd5);
  put_word(i_type(12'd3, 9, 3'b000, 16, OPC_LOAD));
  expect_retire(84, 16, 1, 64'hffff_ffff_ffff_ffff);
  // branches and jumps, x17 is set only on a wrong path
  put_word(b_type(13'd8, 5, 1, 3'b000));
  expect_retire(88, 0, 0, 64'd0);
  put_word(i_type(12'd1, 0, 3'b000, 17, OPC_OP_IMM));
  put_word(b_type(13'd8, 5, 1, 3'b001));
  expect_retire(96, 0, 0, 64'd0);
  put_word(b_type(13'd8, 3, 1, 3'b000));
  expect_retire(100, 0, 0, 64'd0);
  put_word(b_type(13'd8, 3, 1, 3'b001));
  expect_retire(104, 0, 0, 64'd0);
  put_word(i_type(12'd1, 0, 3'b000, 17, OPC_OP_IMM));
  put_word(j_type(21'd12, 18));
  expect_retire(112, 18, 1, 64'd116);
  put_word(i_type(12'd1, 0, 3'b000, 17, OPC_OP_IMM));
  put_word(i_type(12'd1, 0, 3'b000, 17, OPC_OP_IMM));
  put_word(i_type(12'd140, 0, 3'b000, 19, OPC_OP_IMM));
  expect_retire(124, 19, 1, 64'd140);
  // target 145 lands on 144 once bit 0 is cleared
  put_word(i_type(12'd5, 19, 3'b000, 20, OPC_JALR));
  expect_retire(128, 20, 1, 64'd132);
  put_word(i_type(12'd1, 0, 3'b000, 17, OPC_OP_IMM));
  put_word(i_type(12'd1, 0, 3'b000, 17, OPC_OP_IMM));
  put_word(i_type(12'd1, 0, 3'b000, 17, OPC_OP_IMM));
  put_word(i_type(12'd0, 17, 3'b000, 21, OPC_OP_IMM));
  expect_retire(144, 21, 1, 64'd0);
  put_word(32'h0000_0073);
  expect_retire(148, 0, 0, 64'd0);
endtask

`endif

//--- tests/core_tb.sv
// core testbench: loads the program, checks each retire record, timing and halt
`timescale 1ns/10ps
`default_nettype none

`include "core_settings.svh"

module core_tb;
  import core_pkg::*;

  logic                clk = 1'b0;
  logic                rst;
  logic                start;
  logic                imem_load_en;
  logic [`IMEM_AW-1:0] imem_load_addr;
  logic [31:0]         imem_load_data;
  logic                retire_valid;
  retire_t             retire;
  logic                halt;

  int ret_idx;
  int cyc;
  int mark_cyc;
  logic if_seen;
  logic halted_prev;
  int run_cycles;
  int cycle_limit;

  `include "tb_programs.svh"

  rv_core_top rv_core_top_inst (
    .clk            (clk),
    .rst            (rst),
    .start          (start),
    .imem_load_en   (imem_load_en),
    .imem_load_addr (imem_load_addr),
    .imem_load_data (imem_load_data),
    .retire_valid   (retire_valid),
    .retire         (retire),
    .halt           (halt)
  );

  always #10 clk = ~clk;

  task automatic abort_run();
    $display("** FAIL **");
    $fatal(1, "run stopped on error");
  endtask

  task automatic report_error(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    abort_run();
  endtask

  // imem only takes writes in reset, so each window loads up to 16 words
  task automatic load_window(input int base);
    for (int i = 0; i < 16; i++) begin
      @(posedge clk);
      rst <= 1'b1;
      if (base + i < prog_n) begin
        imem_load_en   <= 1'b1;
        imem_load_addr <= (`IMEM_AW)'(base + i);
        imem_load_data <= prog[base + i];
      end else begin
        imem_load_en <= 1'b0;
      end
    end
    @(posedge clk);
    imem_load_en <= 1'b0;
    rst          <= 1'b0;
  endtask

  always @(posedge clk) begin
    if (rst) begin
      ret_idx     <= 0;
      cyc         <= 0;
      mark_cyc    <= 0;
      if_seen     <= 1'b0;
      halted_prev <= 1'b0;
    end else begin
      cyc         <= cyc + 1;
      halted_prev <= halt;
      if (retire_valid) begin
        ret_idx <= ret_idx + 1;
      end
      // first token entry into fetch, then every retire
      if (!if_seen && rv_core_top_inst.stage == st_if) begin
        if_seen  <= 1'b1;
        mark_cyc <= cyc;
      end else if (retire_valid) begin
        mark_cyc <= cyc;
      end
    end
  end

  always @(posedge clk) begin
    if (start) begin
      run_cycles <= run_cycles + 1;
      if (run_cycles >= cycle_limit) begin
        $display("timeout: the core did not halt within %0d cycles", cycle_limit);
        abort_run();
      end
    end
  end

  retire_in_range: assert property (@(posedge clk) disable iff (rst)
    retire_valid |-> ret_idx < rec_n)
    else report_error("more retires than expected records");

  retire_pc_ok: assert property (@(posedge clk) disable iff (rst)
    retire_valid |-> retire.pc == exp_pc[ret_idx])
    else report_error("retire pc differs from the expected record");

  retire_wen_ok: assert property (@(posedge clk) disable iff (rst)
    retire_valid |-> retire.rd_wen == exp_wen[ret_idx])
    else report_error("retire rd_wen differs from the expected record");

  retire_rd_ok: assert property (@(posedge clk) disable iff (rst)
    (retire_valid && exp_wen[ret_idx]) |-> retire.rd == exp_rd[ret_idx])
    else report_error("retire rd differs from the expected record");

  retire_value_ok: assert property (@(posedge clk) disable iff (rst)
    retire_valid |-> retire.rd_value == exp_val[ret_idx])
    else report_error("retire rd_value differs from the expected record");

  retire_spacing: assert property (@(posedge clk) disable iff (rst)
    retire_valid |-> (if_seen && (cyc - mark_cyc == 5)))
    else report_error("retire not 5 cycles after fetch entry or the previous retire");

  halt_on_last: assert property (@(posedge clk) disable iff (rst)
    (halt && !halted_prev) |-> (retire_valid && ret_idx == rec_n - 1))
    else report_error("halt raised before the ecall retired");

  halt_held: assert property (@(posedge clk) disable iff (rst)
    halted_prev |-> (halt && !retire_valid))
    else report_error("halt dropped or a retire followed it");

  initial begin
    rst            = 1'b1;
    start          = 1'b0;
    imem_load_en   = 1'b0;
    imem_load_addr = '0;
    imem_load_data = '0;
    run_cycles     = 0;
    build_program();
    cycle_limit = prog_n * 5 + 50;
    for (int base = 0; base < prog_n; base += 16) begin
      load_window(base);
    end
    start <= 1'b1;
    wait (halt === 1'b1);
    repeat (20) @(posedge clk);
    if (ret_idx == rec_n) begin
      $display("** PASS **");
      $finish;
    end else begin
      report_error("halted before all expected records retired");
    end
  end

endmodule

`default_nettype wire

//--- source/rv_core_top.sv
// rv64i core top: stages, memories, pc, writeback and retire record
`timescale 1ns/10ps
`default_nettype none

`include "core_settings.svh"

module rv_core_top (
  input  logic                clk,
  input  logic                rst,
  input  logic                start,
  input  logic                imem_load_en,
  input  logic [`IMEM_AW-1:0] imem_load_addr,
  input  logic [31:0]         imem_load_data,
  output logic                retire_valid,
  output core_pkg::retire_t   retire,
  output logic                halt
);
  import core_pkg::*;

  stage_t           stage;
  logic             if_pulse;
  logic             id_pulse;
  logic             ex_pulse;
  logic             mem_pulse;
  logic             wb_pulse;
  logic [`XLEN-1:0] pc;
  logic [31:0]      inst;
  logic [4:0]       rs1_addr;
  logic [4:0]       rs2_addr;
  logic [`XLEN-1:0] rs1_data;
  logic [`XLEN-1:0] rs2_data;
  dec_t             dec;
  exe_t             exe;
  logic [`XLEN-1:0] ex_addr;
  logic [`XLEN-1:0] dmem_rdata;
  logic             dmem_wen;
  logic [`XLEN-1:0] dmem_wdata;
  logic [`XLEN-1:0] load_value;
  logic [`XLEN-1:0] wb_value;

  stage_ctrl stage_ctrl_inst (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .halt_req  (exe.is_halt),
    .stage     (stage),
    .if_pulse  (if_pulse),
    .id_pulse  (id_pulse),
    .ex_pulse  (ex_pulse),
    .mem_pulse (mem_pulse),
    .wb_pulse  (wb_pulse),
    .halt      (halt)
  );

  // program load only while held in reset
  mem_array #(
    .word_t (logic [31:0]),
    .depth  (`IMEM_DEPTH)
  ) imem_inst (
    .clk   (clk),
    .ren   (if_pulse),
    .raddr (pc[`IMEM_AW+1:2]),
    .rdata (inst),
    .wen   (imem_load_en && rst),
    .waddr (imem_load_addr),
    .wdata (imem_load_data)
  );

  id_stage id_stage_inst (
    .clk      (clk),
    .rst      (rst),
    .id_pulse (id_pulse),
    .inst     (inst),
    .pc       (pc),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .dec      (dec)
  );

  reg_file reg_file_inst (
    .clk      (clk),
    .rst      (rst),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wen      (wb_pulse && exe.rd_wen),
    .waddr    (exe.rd),
    .wdata    (wb_value)
  );

  exec_unit exec_unit_inst (
    .clk      (clk),
    .rst      (rst),
    .ex_pulse (ex_pulse),
    .pc       (pc),
    .dec      (dec),
    .exe      (exe)
  );

  // old word is fetched during execute for loads and stores
  assign ex_addr = dec.op1 + dec.op2;

  mem_array #(
    .word_t (logic [`XLEN-1:0]),
    .depth  (`DMEM_DEPTH)
  ) dmem_inst (
    .clk   (clk),
    .ren   (ex_pulse && (dec.mem_ren || dec.mem_wen)),
    .raddr (ex_addr[`DMEM_AW+2:3]),
    .rdata (dmem_rdata),
    .wen   (dmem_wen),
    .waddr (exe.addr[`DMEM_AW+2:3]),
    .wdata (dmem_wdata)
  );

  lsu lsu_inst (
    .exe        (exe),
    .mem_pulse  (mem_pulse),
    .rdata      (dmem_rdata),
    .wen        (dmem_wen),
    .wdata      (dmem_wdata),
    .load_value (load_value)
  );

  assign wb_value = exe.mem_ren ? load_value : exe.result;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc           <= `RESET_PC;
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= wb_pulse;
      if (wb_pulse) begin
        pc <= exe.next_pc;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wb_pulse) begin
      retire.pc       <= pc;
      retire.rd       <= exe.rd;
      retire.rd_wen   <= exe.rd_wen;
      retire.rd_value <= exe.rd_wen ? wb_value : '0;
    end
  end

endmodule

`default_nettype wire

//--- source/mem_array.sv
// memory array: synchronous read and write of one word type per instance
`timescale 1ns/10ps
`default_nettype none

module mem_array #(
  parameter type word_t = logic [31:0],
  parameter int  depth  = 256
) (
  input  logic                     clk,
  input  logic                     ren,
  input  logic [$clog2(depth)-1:0] raddr,
  output word_t                    rdata,
  input  logic                     wen,
  input  logic [$clog2(depth)-1:0] waddr,
  input  word_t                    wdata
);

  word_t mem [depth];

  always_ff @(posedge clk) begin
    if (wen) begin
      mem[waddr] <= wdata;
    end
  end

  // rdata holds until the next read
  always_ff @(posedge clk) begin
    if (ren) begin
      rdata <= mem[raddr];
    end
  end

endmodule

`default_nettype wire

//--- source/lsu.sv
// load/store unit: store merge into the old word and sign-extended load extract
`timescale 1ns/10ps
`default_nettype none

`include "core_settings.svh"

module lsu (
  input  core_pkg::exe_t   exe,
  input  logic             mem_pulse,
  input  logic [`XLEN-1:0] rdata,
  output logic             wen,
  output logic [`XLEN-1:0] wdata,
  output logic [`XLEN-1:0] load_value
);

  logic [2:0]       offset;
  logic [5:0]       bit_shift;
  logic [7:0]       byte_mask;
  logic [`XLEN-1:0] bit_mask;
  logic [`XLEN-1:0] shifted;
  logic             aligned;

  assign offset    = exe.addr[2:0];
  assign bit_shift = {offset, 3'b000};
  assign byte_mask = exe.wmask << offset;

  always_comb begin
    for (int i = 0; i < 8; i++) begin
      bit_mask[i*8 +: 8] = {8{byte_mask[i]}};
    end
  end

  assign wen   = mem_pulse && exe.mem_wen;
  assign wdata = (rdata & ~bit_mask) | ((exe.store_data << bit_shift) & bit_mask);

  // byte lane of the load moved down to bit 0
  assign shifted = rdata >> bit_shift;

  always_comb begin
    case (exe.funct3[1:0])
      2'b00:   load_value = {{(`XLEN-8){shifted[7]}}, shifted[7:0]};
      2'b01:   load_value = {{(`XLEN-16){shifted[15]}}, shifted[15:0]};
      2'b10:   load_value = {{(`XLEN-32){shifted[31]}}, shifted[31:0]};
      default: load_value = shifted;
    endcase
  end

  always_comb begin
    case (exe.funct3[1:0])
      2'b00:   aligned = 1'b1;
      2'b01:   aligned = (offset[0] == 1'b0);
      2'b10:   aligned = (offset[1:0] == 2'b00);
      default: aligned = (offset == 3'b000);
    endcase
  end

  // checked as the memory cycle closes
  access_aligned: assert property (@(negedge mem_pulse)
    (exe.mem_ren || exe.mem_wen) |-> aligned);

endmodule

`default_nettype wire

//--- source/exec_unit.sv
// execute stage: add/sub, branch compare and next pc into exe_t
`timescale 1ns/10ps
`default_nettype none

`include "core_settings.svh"

module exec_unit (
  input  logic             clk,
  input  logic             rst,
  input  logic             ex_pulse,
  input  logic [`XLEN-1:0] pc,
  input  core_pkg::dec_t   dec,
  output core_pkg::exe_t   exe
);
  import core_pkg::*;

  logic [`XLEN-1:0] sum;
  logic [`XLEN-1:0] pc_plus4;
  logic             taken;
  exe_t             exe_d;

  assign sum      = dec.sub ? (dec.op1 - dec.op2) : (dec.op1 + dec.op2);
  assign pc_plus4 = pc + 4;

  // beq and bne only
  always_comb begin
    taken = 1'b0;
    if (dec.is_branch) begin
      case (dec.funct3)
        3'b000:  taken = (dec.op1 == dec.op2);
        3'b001:  taken = (dec.op1 != dec.op2);
        default: taken = 1'b0;
      endcase
    end
  end

  always_comb begin
    exe_d            = '0;
    exe_d.result     = sum;
    exe_d.next_pc    = pc_plus4;
    exe_d.rd         = dec.rd;
    exe_d.rd_wen     = dec.rd_wen;
    exe_d.mem_ren    = dec.mem_ren;
    exe_d.mem_wen    = dec.mem_wen;
    exe_d.wmask      = dec.wmask;
    exe_d.funct3     = dec.funct3;
    exe_d.store_data = dec.rs2_data;
    exe_d.is_halt    = dec.is_halt;
    if (dec.mem_ren || dec.mem_wen) begin
      exe_d.addr = sum;
    end
    if (dec.is_jump) begin
      if (dec.is_jalr) begin
        exe_d.result  = dec.t1;
        exe_d.next_pc = {sum[`XLEN-1:1], 1'b0};
      end else begin
        // jal carries link in op1 and target in op2
        exe_d.result  = dec.op1;
        exe_d.next_pc = dec.op2;
      end
    end else if (taken) begin
      exe_d.next_pc = dec.t1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      exe <= '0;
    end else if (ex_pulse) begin
      exe <= exe_d;
    end
  end

endmodule

`default_nettype wire

//--- source/reg_file.sv
// integer register file: 32 x XLEN, two async reads, one write, x0 fixed at zero
`timescale 1ns/10ps
`default_nettype none

`include "core_settings.svh"

module reg_file (
  input  logic             clk,
  input  logic             rst,
  input  logic [4:0]       rs1_addr,
  input  logic [4:0]       rs2_addr,
  output logic [`XLEN-1:0] rs1_data,
  output logic [`XLEN-1:0] rs2_data,
  input  logic             wen,
  input  logic [4:0]       waddr,
  input  logic [`XLEN-1:0] wdata
);

  logic [`XLEN-1:0] regs [32];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && waddr != 5'd0) begin
      regs[waddr] <= wdata;
    end
  end

  // x0 is never written so it reads zero
  assign rs1_data = regs[rs1_addr];
  assign rs2_data = regs[rs2_addr];

endmodule

`default_nettype wire

//--- source/id_stage.sv
// decode stage: immediates, operand select and memory controls into dec_t
`timescale 1ns/10ps
`default_nettype none

`include "core_settings.svh"

module id_stage (
  input  logic             clk,
  input  logic             rst,
  input  logic             id_pulse,
  input  logic [31:0]      inst,
  input  logic [`XLEN-1:0] pc,
  input  logic [`XLEN-1:0] rs1_data,
  input  logic [`XLEN-1:0] rs2_data,
  output logic [4:0]       rs1_addr,
  output logic [4:0]       rs2_addr,
  output core_pkg::dec_t   dec
);
  import core_pkg::*;

  opcode_t          opcode;
  inst_class_t      cls;
  logic [2:0]       funct3;
  logic [4:0]       rd;
  logic [`XLEN-1:0] imm;
  logic [`XLEN-1:0] pc_plus4;
  dec_t             dec_d;

  assign opcode   = opcode_t'(inst[6:2]);
  assign rd       = inst[11:7];
  assign funct3   = inst[14:12];
  assign rs1_addr = inst[19:15];
  assign rs2_addr = inst[24:20];
  assign pc_plus4 = pc + 4;

  always_comb begin
    case (opcode)
      opc_lui, opc_auipc: cls = cls_u;
      opc_jal:            cls = cls_j;
      opc_branch:         cls = cls_b;
      opc_store:          cls = cls_s;
      opc_op:             cls = cls_r;
      opc_jalr, opc_load, opc_op_imm, opc_fence, opc_system: cls = cls_i;
      default:            cls = cls_none;
    endcase
  end

  // sign-extended immediate per format
  always_comb begin
    case (cls)
      cls_i:   imm = {{(`XLEN-12){inst[31]}}, inst[31:20]};
      cls_s:   imm = {{(`XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
      cls_b:   imm = {{(`XLEN-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      cls_u:   imm = {{(`XLEN-32){inst[31]}}, inst[31:12], 12'b0};
      cls_j:   imm = {{(`XLEN-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      default: imm = '0;
    endcase
  end

  always_comb begin
    dec_d          = '0;
    dec_d.rd       = rd;
    dec_d.funct3   = funct3;
    dec_d.rs2_data = rs2_data;
    case (cls)
      cls_r: begin
        dec_d.op1    = rs1_data;
        dec_d.op2    = rs2_data;
        dec_d.sub    = inst[30];
        dec_d.rd_wen = (funct3 == 3'b000);
      end
      cls_i: begin
        dec_d.op1 = rs1_data;
        dec_d.op2 = imm;
      end
      cls_s: begin
        dec_d.op1     = rs1_data;
        dec_d.op2     = imm;
        dec_d.mem_wen = 1'b1;
        case (funct3[1:0])
          2'b00:   dec_d.wmask = 8'h01;
          2'b01:   dec_d.wmask = 8'h03;
          2'b10:   dec_d.wmask = 8'h0f;
          default: dec_d.wmask = 8'hff;
        endcase
      end
      cls_b: begin
        dec_d.op1       = rs1_data;
        dec_d.op2       = rs2_data;
        dec_d.t1        = pc + imm;
        dec_d.is_branch = 1'b1;
      end
      cls_u: begin
        dec_d.op1    = (opcode == opc_auipc) ? pc : '0;
        dec_d.op2    = imm;
        dec_d.rd_wen = 1'b1;
      end
      cls_j: begin
        dec_d.op1     = pc_plus4;
        dec_d.op2     = pc + imm;
        dec_d.is_jump = 1'b1;
        dec_d.rd_wen  = 1'b1;
      end
      default: ;
    endcase
    // I-format opcodes differ only in their controls
    case (opcode)
      opc_jalr: begin
        dec_d.t1      = pc_plus4;
        dec_d.is_jump = 1'b1;
        dec_d.is_jalr = 1'b1;
        dec_d.rd_wen  = 1'b1;
      end
      opc_load: begin
        dec_d.mem_ren = 1'b1;
        dec_d.rd_wen  = 1'b1;
      end
      opc_op_imm: dec_d.rd_wen  = (funct3 == 3'b000);
      opc_system: dec_d.is_halt = (funct3 == 3'b000) && (inst[31:20] == 12'h000);
      default: ;
    endcase
    if (rd == 5'd0) begin
      dec_d.rd_wen = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      dec <= '0;
    end else if (id_pulse) begin
      dec <= dec_d;
    end
  end

  mem_dir_excl: assert property (@(posedge clk) disable iff (rst)
    !(dec.mem_ren && dec.mem_wen));

endmodule

`default_nettype wire

//--- source/stage_ctrl.sv
// stage sequencer: moves the one-hot token, gives entry pulses and holds halt
`timescale 1ns/10ps
`default_nettype none

module stage_ctrl (
  input  logic             clk,
  input  logic             rst,
  input  logic             start,
  input  logic             halt_req,
  output core_pkg::stage_t stage,
  output logic             if_pulse,
  output logic             id_pulse,
  output logic             ex_pulse,
  output logic             mem_pulse,
  output logic             wb_pulse,
  output logic             halt
);
  import core_pkg::*;

  stage_t prev_stage;
  stage_t next_stage;

  always_comb begin
    case (stage)
      st_empty: next_stage = (start && !halt) ? st_if : st_empty;
      st_if:    next_stage = st_id;
      st_id:    next_stage = st_ex;
      st_ex:    next_stage = st_mem;
      st_mem:   next_stage = st_wb;
      // ecall parks the token for good
      st_wb:    next_stage = (start && !halt_req) ? st_if : st_empty;
      default:  next_stage = st_empty;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      stage      <= st_empty;
      prev_stage <= st_empty;
      halt       <= 1'b0;
    end else begin
      stage      <= next_stage;
      prev_stage <= stage;
      if (stage == st_wb && halt_req) begin
        halt <= 1'b1;
      end
    end
  end

  // high only on the cycle the token arrives
  assign if_pulse  = (stage == st_if)  && (prev_stage != st_if);
  assign id_pulse  = (stage == st_id)  && (prev_stage != st_id);
  assign ex_pulse  = (stage == st_ex)  && (prev_stage != st_ex);
  assign mem_pulse = (stage == st_mem) && (prev_stage != st_mem);
  assign wb_pulse  = (stage == st_wb)  && (prev_stage != st_wb);

  token_onehot: assert property (@(posedge clk) disable iff (rst) $onehot(stage));

endmodule

`default_nettype wire

//--- source/core_pkg.sv
// core package: stage token, opcode and format encodings, records between stages
`default_nettype none

`include "core_settings.svh"

package core_pkg;

  // one-hot stage token
  typedef enum logic [5:0] {
    st_empty = 6'b000001,
    st_if    = 6'b000010,
    st_id    = 6'b000100,
    st_ex    = 6'b001000,
    st_mem   = 6'b010000,
    st_wb    = 6'b100000
  } stage_t;

  // opcode field, inst[6:2]
  typedef enum logic [4:0] {
    opc_load   = 5'b00000,
    opc_fence  = 5'b00011,
    opc_op_imm = 5'b00100,
    opc_auipc  = 5'b00101,
    opc_store  = 5'b01000,
    opc_op     = 5'b01100,
    opc_lui    = 5'b01101,
    opc_branch = 5'b11000,
    opc_jalr   = 5'b11001,
    opc_jal    = 5'b11011,
    opc_system = 5'b11100
  } opcode_t;

  typedef enum logic [2:0] {
    cls_none,
    cls_r,
    cls_i,
    cls_s,
    cls_b,
    cls_u,
    cls_j
  } inst_class_t;

  // decode to execute
  typedef struct packed {
    logic [`XLEN-1:0] op1;
    logic [`XLEN-1:0] op2;
    logic [`XLEN-1:0] t1;
    logic [`XLEN-1:0] rs2_data;
    logic [4:0]       rd;
    logic             rd_wen;
    logic             mem_ren;
    logic             mem_wen;
    logic [7:0]       wmask;
    logic [2:0]       funct3;
    logic             sub;
    logic             is_branch;
    logic             is_jump;
    logic             is_jalr;
    logic             is_halt;
  } dec_t;

  // execute to lsu and writeback
  typedef struct packed {
    logic [`XLEN-1:0] result;
    logic [`XLEN-1:0] addr;
    logic [`XLEN-1:0] next_pc;
    logic [4:0]       rd;
    logic             rd_wen;
    logic             mem_ren;
    logic             mem_wen;
    logic [7:0]       wmask;
    logic [2:0]       funct3;
    logic [`XLEN-1:0] store_data;
    logic             is_halt;
  } exe_t;

  typedef struct packed {
    logic [`XLEN-1:0] pc;
    logic [4:0]       rd;
    logic             rd_wen;
    logic [`XLEN-1:0] rd_value;
  } retire_t;

endpackage

`default_nettype wire

//--- source/core_settings.svh
// core settings: datapath width, memory sizes and reset pc
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// register and data width
`define XLEN 64

// instruction memory in 32-bit words
`define IMEM_DEPTH 256
`define IMEM_AW $clog2(`IMEM_DEPTH)

// data memory in 64-bit words
`define DMEM_DEPTH 256
`define DMEM_AW $clog2(`DMEM_DEPTH)

// first fetch address
`define RESET_PC 64'h0

`endif
